/* bench/tb_display.sv */
// Directed testbench for the four-digit seven-segment display
// Expected segments come from a model of the decoder table and the ripple-blanking rule
// All inputs change 1 ns after a rising edge and outputs are sampled at that point too
`timescale 1ns/1ps

module tb_display;

	// Cycles that arst_n stays low
	localparam int RESET_CYCLES = 16;
	// Transfers over all tests are 6 directed, 3 overflow and 12 random
	localparam int TRANSFERS = 21;
	// Slack per transfer for held req and static input changes
	localparam int MAX_EXTRA = 4;
	localparam int TIMEOUT_CYCLES =
		TRANSFERS * (seg7_pkg::VALUE_W + 8 + MAX_EXTRA) + RESET_CYCLES;

	logic                         clk;
	logic                         arst_n;
	logic                         req;
	logic [seg7_pkg::VALUE_W-1:0] value;
	logic                         lamp_test;
	logic                         zero_blank;
	logic                         ack;
	logic                         overflow;
	logic [seg7_pkg::SEG_W-1:0]   seg0;
	logic [seg7_pkg::SEG_W-1:0]   seg1;
	logic [seg7_pkg::SEG_W-1:0]   seg2;
	logic [seg7_pkg::SEG_W-1:0]   seg3;

	// Value of the last completed transfer before saturation
	logic [seg7_pkg::VALUE_W-1:0] last_value;

	integer seed;
	int     errors;
	int     checks;
	int     cycles;

	display_top u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (req),
		.value      (value),
		.lamp_test  (lamp_test),
		.zero_blank (zero_blank),
		.ack        (ack),
		.overflow   (overflow),
		.seg0       (seg0),
		.seg1       (seg1),
		.seg2       (seg2),
		.seg3       (seg3)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog on the total run length
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles",
				TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Simulation failed");
			$finish;
		end
	end

	// Lit segments of each decimal digit in the order a to g as the TTL chip draws them
	// Six has no top bar and nine has no bottom bar on this chip
	function automatic logic [seg7_pkg::SEG_W-1:0] lit_pattern(input int unsigned d);
		case (d)
			0:       return 7'b1111110;
			1:       return 7'b0110000;
			2:       return 7'b1101101;
			3:       return 7'b1111001;
			4:       return 7'b0110011;
			5:       return 7'b1011011;
			6:       return 7'b0011111;
			7:       return 7'b1110000;
			8:       return 7'b1111111;
			9:       return 7'b1110011;
			default: return 7'b0000000;
		endcase
	endfunction

	// Reference model of the whole display where index 0 is the least significant digit
	function automatic logic [seg7_pkg::NUM_DIGITS-1:0][seg7_pkg::SEG_W-1:0] expected_segs(
		input int unsigned v,
		input logic        lt,
		input logic        zb
	);
		logic [seg7_pkg::NUM_DIGITS-1:0][seg7_pkg::SEG_W-1:0] segs;
		int unsigned shown;
		int unsigned d;
		int unsigned scale;
		logic        leading;
		shown = (v > seg7_pkg::MAX_VALUE) ? seg7_pkg::MAX_VALUE : v;
		leading = zb;
		scale = 1000;
		for (int i = seg7_pkg::NUM_DIGITS - 1; i >= 0; i--) begin
			d = (shown / scale) % 10;
			// Still leading only while every digit from the top down is zero
			leading = leading && (d == 0);
			if (lt) begin
				segs[i] = '0;
			end else if (leading && i != 0) begin
				segs[i] = '1;
			end else begin
				segs[i] = ~lit_pattern(d);
			end
			scale = scale / 10;
		end
		return segs;
	endfunction

	task automatic check_segs(
		input logic [seg7_pkg::NUM_DIGITS-1:0][seg7_pkg::SEG_W-1:0] got,
		input logic [seg7_pkg::NUM_DIGITS-1:0][seg7_pkg::SEG_W-1:0] exp,
		input string                                                what
	);
		for (int i = 0; i < seg7_pkg::NUM_DIGITS; i++) begin
			checks++;
			if (got[i] !== exp[i]) begin
				errors++;
				$display("FAILED at %0d ns: %s, seg%0d is %b, expected %b",
					$time, what, i, got[i], exp[i]);
			end
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Compares all four digits against the model for the current static inputs
	task automatic check_display(input string what);
		check_segs({seg3, seg2, seg1, seg0},
			expected_segs(last_value, lamp_test, zero_blank), what);
	endtask

	// Changes the static inputs and lets one clock pass
	task automatic set_static(input logic lt, input logic zb);
		lamp_test = lt;
		zero_blank = zb;
		@(posedge clk);
		#1;
	endtask

	// One full four-phase transfer that keeps req high for hold cycles after ack
	task automatic send_value(input logic [seg7_pkg::VALUE_W-1:0] v, input int hold);
		check_flag(ack, 1'b0, "ack before req");
		value = v;
		req = 1'b1;
		// Wait until the display register has taken the value
		do begin
			@(posedge clk);
			#1;
		end while (!ack);
		repeat (hold) begin
			@(posedge clk);
			#1;
			check_flag(ack, 1'b1, "ack while req is held");
		end
		req = 1'b0;
		last_value = v;
		// ack is still high on the edge that first sees req low
		@(posedge clk);
		#1;
		check_flag(ack, 1'b1, "ack on the edge after req fell");
		// It drops on the following edge
		@(posedge clk);
		#1;
		check_flag(ack, 1'b0, "ack one cycle after req was seen low");
	endtask

	task automatic test_reset();
		check_display("display after reset");
		check_flag(overflow, 1'b0, "overflow after reset");
		check_flag(ack, 1'b0, "ack after reset");
	endtask

	// Blanked and unblanked views of the same stored value
	task automatic test_directed();
		int unsigned vals[6];
		vals = '{0, 7, 40, 305, 1000, 9999};
		foreach (vals[k]) begin
			send_value(seg7_pkg::VALUE_W'(vals[k]), 0);
			check_display("zero_blank high");
			check_flag(overflow, 1'b0, "overflow in range");
			set_static(1'b0, 1'b0);
			check_display("zero_blank low");
			set_static(1'b0, 1'b1);
		end
	endtask

	task automatic test_overflow();
		send_value(seg7_pkg::VALUE_W'(10000), 0);
		check_display("saturated 10000");
		check_flag(overflow, 1'b1, "overflow for 10000");
		send_value(seg7_pkg::VALUE_W'(16383), 0);
		check_display("saturated 16383");
		check_flag(overflow, 1'b1, "overflow for 16383");
		// An in-range value clears the flag
		send_value(seg7_pkg::VALUE_W'(12), 0);
		check_display("value 12 after overflow");
		check_flag(overflow, 1'b0, "overflow cleared");
	endtask

	task automatic test_lamp();
		set_static(1'b1, 1'b1);
		check_segs({seg3, seg2, seg1, seg0}, '0, "lamp test with zero_blank high");
		set_static(1'b1, 1'b0);
		check_segs({seg3, seg2, seg1, seg0}, '0, "lamp test with zero_blank low");
		set_static(1'b0, 1'b1);
		check_display("after lamp test");
	endtask

	task automatic test_random();
		logic [seg7_pkg::VALUE_W-1:0] v;
		for (int i = 0; i < 12; i++) begin
			v = $random(seed) & 32'h3fff;
			send_value(v, 1 + i % 3);
			check_display("random value");
			check_flag(overflow, v > seg7_pkg::MAX_VALUE, "overflow for random value");
		end
	endtask

	initial begin
		seed = 33905;
		errors = 0;
		checks = 0;
		cycles = 0;
		last_value = '0;
		arst_n = 1'b0;
		req = 1'b0;
		value = '0;
		lamp_test = 1'b0;
		zero_blank = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
		test_reset();
		test_directed();
		test_overflow();
		test_lamp();
		test_random();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
hdl/seg7_pkg.sv
hdl/bin_to_bcd.sv
hdl/bcd_seg_decoder.sv
hdl/display_ctrl.sv
hdl/display_top.sv
bench/tb_display.sv

/* hdl/bcd_seg_decoder.sv */
// One BCD digit to active-low seven segments, after the TTL decoder chip
// Codes 10 to 14 show the chip's odd glyphs and code 15 is dark
// Purely combinational, the blanking input and output are separate wires
`timescale 1ns/1ps

module bcd_seg_decoder (
	input  logic [3:0]                 digit,
	input  logic                       lamp_test,
	input  logic                       rb_in_n,
	output logic                       rb_out_n,
	output logic [seg7_pkg::SEG_W-1:0] seg
);

	// High when this digit is a suppressed leading zero
	logic blank;

	// Segment pattern of the digit before lamp test and blanking
	logic [seg7_pkg::SEG_W-1:0] glyph;

	// A zero is only dark when every digit above it was dark as well,
	// and lamp test always wins over blanking
	assign blank = !lamp_test && !rb_in_n && (digit == 4'd0);

	// Tells the next lower digit that everything up to here was dark
	assign rb_out_n = !blank;

	// Decoding table of the chip, a low bit lights the segment
	// Order of the bits is a b c d e f g
	always_comb begin
		case (digit)
			4'd0:  glyph = 7'b0000001;
			4'd1:  glyph = 7'b1001111;
			4'd2:  glyph = 7'b0010010;
			4'd3:  glyph = 7'b0000110;
			4'd4:  glyph = 7'b1001100;
			4'd5:  glyph = 7'b0100100;
			// The chip draws six without the top bar
			4'd6:  glyph = 7'b1100000;
			4'd7:  glyph = 7'b0001111;
			4'd8:  glyph = 7'b0000000;
			// and nine without the bottom bar
			4'd9:  glyph = 7'b0001100;
			// Codes above nine give partial shapes of the chip
			4'd10: glyph = 7'b1110010;
			4'd11: glyph = 7'b1100110;
			4'd12: glyph = 7'b1011100;
			4'd13: glyph = 7'b0110100;
			4'd14: glyph = 7'b1110000;
			// Code 15 turns the digit off
			default: glyph = 7'b1111111;
		endcase
	end

	// Lamp test first, then ripple blanking, then the decoded digit
	always_comb begin
		if (lamp_test) begin
			seg = '0;
		end else if (blank) begin
			seg = '1;
		end else begin
			seg = glyph;
		end
	end

endmodule

/* hdl/bin_to_bcd.sv */
// Sequential shift-and-add-three converter, one load cycle plus VALUE_W shifts
// The input must not exceed MAX_VALUE, a carry out of the top digit is lost
// A start that arrives while busy is ignored
`timescale 1ns/1ps

module bin_to_bcd (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         start,
	input  logic [seg7_pkg::VALUE_W-1:0] bin,
	output seg7_pkg::bcd_word_u          bcd,
	output logic                         done,
	output logic                         busy
);

	// Accumulating BCD digits, filled from the bottom as bits shift in
	seg7_pkg::bcd_word_u acc;

	// Accumulator after the add-three correction of this iteration
	seg7_pkg::bcd_word_u adj;

	// Binary bits still to be shifted into the accumulator, MSB first
	logic [seg7_pkg::VALUE_W-1:0] sr;

	// Counts the shift iterations of one conversion
	logic [seg7_pkg::ITER_W-1:0] iter;

	// A new conversion is only taken when the previous one has finished
	logic load;

	assign load = start && !busy;

	// Any digit of five or more gets three added so that the following
	// left shift carries correctly into the next decimal digit
	always_comb begin
		adj = acc;
		for (int i = 0; i < seg7_pkg::NUM_DIGITS; i++) begin
			if (acc.digit[i] >= 4'd5) begin
				adj.digit[i] = acc.digit[i] + 4'd3;
			end
		end
	end

	// Iteration control
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			iter <= '0;
			done <= 1'b0;
		end else begin
			// done lasts a single cycle
			done <= 1'b0;
			if (load) begin
				busy <= 1'b1;
				iter <= '0;
			end else if (busy) begin
				iter <= iter + 1'b1;
				// The last shift lands together with done
				if (iter == seg7_pkg::LAST_ITER) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Datapath of the converter
	always_ff @(posedge clk) begin
		if (load) begin
			acc.raw <= '0;
			sr      <= bin;
		end else if (busy) begin
			// Corrected digits move up one bit and take the next binary bit
			acc.raw <= {adj.raw[seg7_pkg::BCD_W-2:0], sr[seg7_pkg::VALUE_W-1]};
			sr      <= {sr[seg7_pkg::VALUE_W-2:0], 1'b0};
		end
	end

	// Valid in the done cycle and held until the next load
	assign bcd = acc;

endmodule

/* hdl/display_ctrl.sv */
// Four-phase req/ack handshake in front of the BCD converter and display register
// The host holds value stable while req is high and raises req again only after ack falls
// Values above MAX_VALUE are shown as MAX_VALUE with overflow set
`timescale 1ns/1ps

module display_ctrl (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         req,
	input  logic [seg7_pkg::VALUE_W-1:0] value,
	output logic                         ack,
	output logic                         conv_start,
	output logic [seg7_pkg::VALUE_W-1:0] conv_bin,
	input  logic                         conv_done,
	input  seg7_pkg::bcd_word_u          conv_bcd,
	output seg7_pkg::bcd_word_u          bcd_disp,
	output logic                         overflow
);

	// Handshake FSM state
	logic [1:0] state;

	// A new value is taken when the FSM is idle and the host requests
	logic accept;

	// Host value is out of display range
	logic too_big;

	// Delays the start pulse by one cycle behind the latch
	logic launch;

	// Overflow of the value that is being converted right now
	logic ovf_pend;

	assign accept  = (state == seg7_pkg::ST_IDLE) && req;
	assign too_big = value > seg7_pkg::MAX_VALUE;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= seg7_pkg::ST_IDLE;
			launch     <= 1'b0;
			conv_start <= 1'b0;
			ack        <= 1'b0;
			overflow   <= 1'b0;
			bcd_disp   <= '0;
		end else begin
			// The latch happens on the accept edge and start follows one cycle later
			launch     <= accept;
			conv_start <= launch;

			case (state)
				seg7_pkg::ST_IDLE: begin
					if (req) begin
						state <= seg7_pkg::ST_CONVERT;
					end
				end
				seg7_pkg::ST_CONVERT: begin
					// Digits and flag are committed together so they always
					// describe the same host value
					if (conv_done) begin
						bcd_disp <= conv_bcd;
						overflow <= ovf_pend;
						ack      <= 1'b1;
						state    <= seg7_pkg::ST_ACK;
					end
				end
				seg7_pkg::ST_ACK: begin
					// ack holds while the host keeps req high
					if (!req) begin
						state <= seg7_pkg::ST_RELEASE;
					end
				end
				seg7_pkg::ST_RELEASE: begin
					// ack drops one cycle after req was seen low
					ack   <= 1'b0;
					state <= seg7_pkg::ST_IDLE;
				end
				default: begin
					ack   <= 1'b0;
					state <= seg7_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Saturated value and its overflow flag, captured once per transfer
	always_ff @(posedge clk) begin
		if (accept) begin
			conv_bin <= too_big ? seg7_pkg::MAX_VALUE : value;
			ovf_pend <= too_big;
		end
	end

endmodule

/* hdl/display_top.sv */
// Binary value to four seven-segment digits with leading-zero suppression
// Latency from the req sample to ack high is VALUE_W + 3 clock cycles
// lamp_test and zero_blank act on the segments at once, without a clock
`timescale 1ns/1ps

module display_top (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         req,
	input  logic [seg7_pkg::VALUE_W-1:0] value,
	input  logic                         lamp_test,
	input  logic                         zero_blank,
	output logic                         ack,
	output logic                         overflow,
	output logic [seg7_pkg::SEG_W-1:0]   seg0,
	output logic [seg7_pkg::SEG_W-1:0]   seg1,
	output logic [seg7_pkg::SEG_W-1:0]   seg2,
	output logic [seg7_pkg::SEG_W-1:0]   seg3
);

	// Controller to converter
	logic                         conv_start;
	logic                         conv_done;
	logic [seg7_pkg::VALUE_W-1:0] conv_bin;
	seg7_pkg::bcd_word_u          conv_bcd;

	// Stored digits shown on the display
	seg7_pkg::bcd_word_u bcd_disp;

	// Ripple-blanking chain, running from digit 3 down to digit 1
	logic rb3_n;
	logic rb2_n;
	logic rb1_n;

	// Leading zeros are only suppressed when zero_blank asks for it
	assign rb3_n = ~zero_blank;

	display_ctrl u_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (req),
		.value      (value),
		.ack        (ack),
		.conv_start (conv_start),
		.conv_bin   (conv_bin),
		.conv_done  (conv_done),
		.conv_bcd   (conv_bcd),
		.bcd_disp   (bcd_disp),
		.overflow   (overflow)
	);

	bin_to_bcd u_conv (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (conv_start),
		.bin    (conv_bin),
		.bcd    (conv_bcd),
		.done   (conv_done),
		.busy   ()
	);

	bcd_seg_decoder u_dec3 (
		.digit     (bcd_disp.digit[3]),
		.lamp_test (lamp_test),
		.rb_in_n   (rb3_n),
		.rb_out_n  (rb2_n),
		.seg       (seg3)
	);

	bcd_seg_decoder u_dec2 (
		.digit     (bcd_disp.digit[2]),
		.lamp_test (lamp_test),
		.rb_in_n   (rb2_n),
		.rb_out_n  (rb1_n),
		.seg       (seg2)
	);

	// Digit 1's blanking output goes nowhere since digit 0 never blanks
	bcd_seg_decoder u_dec1 (
		.digit     (bcd_disp.digit[1]),
		.lamp_test (lamp_test),
		.rb_in_n   (rb1_n),
		.rb_out_n  (),
		.seg       (seg1)
	);

	// Tied high so that a value of zero still shows a single 0
	bcd_seg_decoder u_dec0 (
		.digit     (bcd_disp.digit[0]),
		.lamp_test (lamp_test),
		.rb_in_n   (1'b1),
		.rb_out_n  (),
		.seg       (seg0)
	);

endmodule

/* hdl/seg7_pkg.sv */
// Shared widths, limits and encodings for the four-digit seven-segment display
// The digit count is fixed by the ripple-blanking wiring in the top level
// Values above MAX_VALUE must be saturated before they reach the converter
package seg7_pkg;

	// Number of display digits, most significant is digit 3
	localparam int unsigned NUM_DIGITS = 4;

	// Bits in one BCD digit
	localparam int unsigned DIGIT_W = 4;

	// Width of the binary value offered by the host
	localparam int unsigned VALUE_W = 14;

	// Width of the packed BCD word holding all digits
	localparam int unsigned BCD_W = NUM_DIGITS * DIGIT_W;

	// Segments per digit, bit 6 is segment a and bit 0 is segment g
	localparam int unsigned SEG_W = 7;

	// Width of the converter's iteration counter
	localparam int unsigned ITER_W = $clog2(VALUE_W);

	// Count value of the final shift-and-add iteration
	localparam logic [ITER_W-1:0] LAST_ITER = ITER_W'(VALUE_W - 1);

	// Largest value four decimal digits can show
	localparam logic [VALUE_W-1:0] MAX_VALUE = VALUE_W'(9999);

	// Handshake controller state encodings
	localparam logic [1:0] ST_IDLE = 2'd0;
	// Waiting for the converter to finish
	localparam logic [1:0] ST_CONVERT = 2'd1;
	// ack high until the host drops req
	localparam logic [1:0] ST_ACK = 2'd2;
	// One more cycle of ack before returning to idle
	localparam logic [1:0] ST_RELEASE = 2'd3;

	// The BCD word is shifted as one raw vector in the converter
	// and split into single digits for the decoders
	// digit[0] is the least significant digit
	typedef union packed {
		logic [BCD_W-1:0] raw;
		logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digit;
	} bcd_word_u;

endpackage
